// File: compile.f
source/conv_acc_pkg.sv
source/clock_gate.sv
source/bus_switcher.sv
source/conv_1x1_unit.sv
source/maxpool_unit.sv
source/conv_acc_top.sv
dv/conv_acc_tb.sv

// File: dv/conv_acc_patterns.txt
// mode | nparam params | nbias bias | nweight weights | ninput inputs | nout expected outputs
// All hex, mode 1 conv, 2 maxpool, 0 idle start pulse, ffff ends the list
// 4x4 max pooling with negative windows
0002
0002 0004 0004
0000
0000
0010 0001 fffe 0005 0003 0004 0002 fff9 0000
     fff6 fffb 0008 0008 fffd fff8 0002 000a
0004 0004 0005 fffd 000a
// 1x1 conv, N=4 C=3 shift 2, pixel 1 goes negative, pixel 2 saturates
0001
0003 0004 0003 0002
0001 0004
0003 0002 ffff 0003
000c 000a fff8 7000 0064 0004 0006 f000 ffce
     0002 0001 7fff ffec
0004 0006 0000 7fff 0030
// 4x2 max pooling right after the conv
0002
0002 0004 0002
0000
0000
0008 0003 0007 fff0 ffff 0009 0002 ffe0 fff1
0002 0009 ffff
// Idle mode, the start pulse must do nothing
0000
0000
0000
0000
0000
0000
ffff

// File: dv/conv_acc_tb.sv
`timescale 1ns/1ps

// Single-port SRAM model with read data one edge after the request
module sram_model (
  input  logic                     clk_i,
  input  conv_acc_pkg::sram_req_t  req_i,
  output conv_acc_pkg::sram_data_t rdata_o
);

  conv_acc_pkg::sram_data_t mem [2**conv_acc_pkg::ADDR_W];

  initial rdata_o = '0;

  always @(posedge clk_i) begin
    if (req_i.cs && req_i.w_req) begin
      mem[req_i.addr] <= req_i.w_data;
    end else if (req_i.cs && req_i.oe) begin
      rdata_o <= mem[req_i.addr];  // Holds until the next read
    end
  end

endmodule

module conv_acc_tb;

  localparam int PAT_WORDS = 256;

  logic                         clk;
  logic                         reset;
  conv_acc_pkg::conv_acc_mode_t mode;
  logic                         start;
  logic                         done;
  conv_acc_pkg::sram_req_t      param_req, bias_req, weight_req, input_req, output_req;
  conv_acc_pkg::sram_data_t     param_rdata, bias_rdata, weight_rdata, input_rdata;
  conv_acc_pkg::sram_data_t     output_rdata;
  logic [15:0]                  pat [PAT_WORDS];
  conv_acc_pkg::sram_data_t     exp_q [$];
  int                           n_writes, n_dones, cycles, cycle_limit;

  conv_acc_top i_dut (
    .clk_i (clk), .reset_i (reset), .mode_i (mode), .start_i (start), .done_o (done),
    .param_req_o  (param_req),  .param_rdata_i  (param_rdata),
    .bias_req_o   (bias_req),   .bias_rdata_i   (bias_rdata),
    .weight_req_o (weight_req), .weight_rdata_i (weight_rdata),
    .input_req_o  (input_req),  .input_rdata_i  (input_rdata),
    .output_req_o (output_req), .output_rdata_i (output_rdata)
  );

  sram_model i_param_sram  (.clk_i (clk), .req_i (param_req),  .rdata_o (param_rdata));
  sram_model i_bias_sram   (.clk_i (clk), .req_i (bias_req),   .rdata_o (bias_rdata));
  sram_model i_weight_sram (.clk_i (clk), .req_i (weight_req), .rdata_o (weight_rdata));
  sram_model i_input_sram  (.clk_i (clk), .req_i (input_req),  .rdata_o (input_rdata));
  sram_model i_output_sram (.clk_i (clk), .req_i (output_req), .rdata_o (output_rdata));

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_write(input conv_acc_pkg::sram_addr_t addr,
                             input conv_acc_pkg::sram_data_t data);
    conv_acc_pkg::sram_data_t exp_data;
    conv_acc_pkg::sram_addr_t exp_addr;
    exp_addr = conv_acc_pkg::sram_addr_t'(n_writes);
    if (exp_q.size() == 0) begin
      fail_run($sformatf("output write to 0x%h came after all expected writes", addr));
    end else begin
      exp_data = exp_q.pop_front();
      n_writes++;
      if (addr !== exp_addr) begin
        fail_run($sformatf("CHECK FAILED output_req_o.addr expected 0x%h got 0x%h",
                           exp_addr, addr));
      end else if (data !== exp_data) begin
        fail_run($sformatf("CHECK FAILED output_req_o.w_data expected 0x%h got 0x%h",
                           exp_data, data));
      end
    end
  endtask

  task automatic check_idle(input string name, input conv_acc_pkg::sram_req_t req);
    conv_acc_pkg::sram_req_t zero_req;
    zero_req = '0;
    if (req !== zero_req) begin
      fail_run($sformatf("CHECK FAILED %s expected 0x%h got 0x%h", name, zero_req, req));
    end
  endtask

  task automatic check_no_done(input logic done_val);
    if (done_val !== 1'b0) begin
      fail_run($sformatf("CHECK FAILED done_o expected 0x0 got 0x%h", done_val));
    end
  endtask

  task automatic check_all_idle();
    check_idle("param_req_o", param_req);
    check_idle("bias_req_o", bias_req);
    check_idle("weight_req_o", weight_req);
    check_idle("input_req_o", input_req);
    check_idle("output_req_o", output_req);
    check_no_done(done);
  endtask

  // Reads and writes per output times outputs, plus a margin per test
  function automatic int timeout_limit();
    int ptr;
    int limit;
    int per_out;
    int nout;
    ptr   = 0;
    limit = 20;  // Reset and idle checks
    while (ptr < PAT_WORDS && pat[ptr] != 16'hffff) begin
      per_out = 5;  // Four window reads and one write
      if (pat[ptr] == 16'd1) per_out = pat[ptr+3] + 1;
      ptr++;
      repeat (4) ptr += pat[ptr] + 1;
      nout  = pat[ptr];
      ptr  += nout + 1;
      limit += per_out * nout + 50;
    end
    return limit;
  endfunction

  task automatic load_mem(input int sel, inout int ptr);
    int n;
    n = pat[ptr];
    ptr++;
    for (int i = 0; i < n; i++) begin
      case (sel)
        0:       i_param_sram.mem[i] = pat[ptr];
        1:       i_bias_sram.mem[i] = pat[ptr];
        2:       i_weight_sram.mem[i] = pat[ptr];
        default: i_input_sram.mem[i] = pat[ptr];
      endcase
      ptr++;
    end
  endtask

  task automatic run_test(inout int ptr);
    conv_acc_pkg::conv_acc_mode_t tmode;
    int nout;
    tmode = conv_acc_pkg::conv_acc_mode_t'(pat[ptr][1:0]);
    ptr++;
    for (int sel = 0; sel < 4; sel++) load_mem(sel, ptr);
    nout = pat[ptr];
    ptr++;
    for (int i = 0; i < nout; i++) begin
      exp_q.push_back(conv_acc_pkg::sram_data_t'(pat[ptr]));
      ptr++;
    end
    n_writes = 0;
    n_dones  = 0;
    @(posedge clk);
    mode <= tmode;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (tmode == conv_acc_pkg::IDLE_MODE) begin
      repeat (20) begin
        @(negedge clk);
        check_all_idle();
      end
    end else begin
      while (n_dones == 0) @(posedge clk);
      if (n_writes != nout) begin
        fail_run($sformatf("done_o came after %0d writes, %0d were expected", n_writes, nout));
      end
      repeat (3) @(posedge clk);
      if (n_dones != 1) fail_run("done_o pulsed more than once in one run");
    end
  endtask

  // Output writes and the maxpool bus checks
  always @(negedge clk) begin
    if (!reset) begin
      if (output_req.cs && output_req.w_req) check_write(output_req.addr, output_req.w_data);
      if (mode == conv_acc_pkg::MAX_POOL_MODE) begin
        check_idle("bias_req_o", bias_req);
        check_idle("weight_req_o", weight_req);
      end
      if (done) n_dones++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      fail_run($sformatf("timeout, done_o never came within %0d cycles", cycle_limit));
    end
  end

  initial begin
    int ptr;
    reset  = 1'b1;
    mode   = conv_acc_pkg::IDLE_MODE;
    start  = 1'b0;
    cycles = 0;
    $readmemh("dv/conv_acc_patterns.txt", pat);
    cycle_limit = timeout_limit();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_all_idle();
    end
    ptr = 0;
    while (ptr < PAT_WORDS && pat[ptr] !== 16'hffff) run_test(ptr);
    repeat (2) @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

// File: source/bus_switcher.sv
`timescale 1ns/1ps

module bus_switcher (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  conv_acc_pkg::conv_acc_mode_t mode_i,
  input  logic                         start_i,
  output logic                         done_o,
  output conv_acc_pkg::sram_req_t      param_req_o,
  input  conv_acc_pkg::sram_data_t     param_rdata_i,
  output conv_acc_pkg::sram_req_t      bias_req_o,
  input  conv_acc_pkg::sram_data_t     bias_rdata_i,
  output conv_acc_pkg::sram_req_t      weight_req_o,
  input  conv_acc_pkg::sram_data_t     weight_rdata_i,
  output conv_acc_pkg::sram_req_t      input_req_o,
  input  conv_acc_pkg::sram_data_t     input_rdata_i,
  output conv_acc_pkg::sram_req_t      output_req_o,
  input  conv_acc_pkg::sram_data_t     output_rdata_i,
  output logic                         conv_clk_o,
  output logic                         conv_start_o,
  input  logic                         conv_done_i,
  input  conv_acc_pkg::sram_req_t      conv_param_req_i,
  output conv_acc_pkg::sram_data_t     conv_param_rdata_o,
  input  conv_acc_pkg::sram_req_t      conv_bias_req_i,
  output conv_acc_pkg::sram_data_t     conv_bias_rdata_o,
  input  conv_acc_pkg::sram_req_t      conv_weight_req_i,
  output conv_acc_pkg::sram_data_t     conv_weight_rdata_o,
  input  conv_acc_pkg::sram_req_t      conv_input_req_i,
  output conv_acc_pkg::sram_data_t     conv_input_rdata_o,
  input  conv_acc_pkg::sram_req_t      conv_output_req_i,
  output conv_acc_pkg::sram_data_t     conv_output_rdata_o,
  output logic                         pool_clk_o,
  output logic                         pool_start_o,
  input  logic                         pool_done_i,
  input  conv_acc_pkg::sram_req_t      pool_param_req_i,
  output conv_acc_pkg::sram_data_t     pool_param_rdata_o,
  input  conv_acc_pkg::sram_req_t      pool_input_req_i,
  output conv_acc_pkg::sram_data_t     pool_input_rdata_o,
  input  conv_acc_pkg::sram_req_t      pool_output_req_i,
  output conv_acc_pkg::sram_data_t     pool_output_rdata_o
);

  logic conv_en;
  logic pool_en;

  assign conv_en = (mode_i == conv_acc_pkg::CONV_1x1_MODE);
  assign pool_en = (mode_i == conv_acc_pkg::MAX_POOL_MODE);

  // Read data fans out to both units and only the selected one listens
  assign conv_param_rdata_o  = param_rdata_i;
  assign conv_bias_rdata_o   = bias_rdata_i;
  assign conv_weight_rdata_o = weight_rdata_i;
  assign conv_input_rdata_o  = input_rdata_i;
  assign conv_output_rdata_o = output_rdata_i;
  assign pool_param_rdata_o  = param_rdata_i;
  assign pool_input_rdata_o  = input_rdata_i;
  assign pool_output_rdata_o = output_rdata_i;

  assign conv_start_o = start_i & conv_en;
  assign pool_start_o = start_i & pool_en;

  always_comb begin
    param_req_o  = '0;  // Idle drives nothing
    bias_req_o   = '0;
    weight_req_o = '0;
    input_req_o  = '0;
    output_req_o = '0;
    done_o       = 1'b0;
    if (conv_en) begin
      param_req_o  = conv_param_req_i;
      bias_req_o   = conv_bias_req_i;
      weight_req_o = conv_weight_req_i;
      input_req_o  = conv_input_req_i;
      output_req_o = conv_output_req_i;
      done_o       = conv_done_i;
    end else if (pool_en) begin
      param_req_o  = pool_param_req_i;
      input_req_o  = pool_input_req_i;
      output_req_o = pool_output_req_i;
      done_o       = pool_done_i;
    end
  end

  // Reset keeps both clocks running so the units clear
  clock_gate i_conv_clock_gate (
    .clk_i       (clk_i),
    .en_i        (conv_en | reset_i),
    .gated_clk_o (conv_clk_o)
  );

  clock_gate i_pool_clock_gate (
    .clk_i       (clk_i),
    .en_i        (pool_en | reset_i),
    .gated_clk_o (pool_clk_o)
  );

endmodule

// File: source/clock_gate.sv
`timescale 1ns/1ps

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  output logic gated_clk_o
);

  logic en_latch;

  // Enable only changes while the clock is low
  always_latch begin
    if (!clk_i) begin
      en_latch <= en_i;
    end
  end

  assign gated_clk_o = clk_i & en_latch;

endmodule

// File: source/conv_1x1_unit.sv
`timescale 1ns/1ps

module conv_1x1_unit (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     start_i,
  output logic                     done_o,
  output conv_acc_pkg::sram_req_t  param_req_o,
  input  conv_acc_pkg::sram_data_t param_rdata_i,
  output conv_acc_pkg::sram_req_t  bias_req_o,
  input  conv_acc_pkg::sram_data_t bias_rdata_i,
  output conv_acc_pkg::sram_req_t  weight_req_o,
  input  conv_acc_pkg::sram_data_t weight_rdata_i,
  output conv_acc_pkg::sram_req_t  input_req_o,
  input  conv_acc_pkg::sram_data_t input_rdata_i,
  output conv_acc_pkg::sram_req_t  output_req_o,
  input  conv_acc_pkg::sram_data_t output_rdata_i
);

  conv_acc_pkg::unit_state_t state;
  logic [1:0]                param_cnt;
  conv_acc_pkg::sram_addr_t  param_addr;
  conv_acc_pkg::sram_addr_t  n_pix, n_ch, pix, ch, in_addr, out_addr;
  logic [4:0]                shift;
  conv_acc_pkg::sram_data_t  bias, out_data, result;
  logic                      param_rd, bias_rd, run_rd, mac_vld, out_wr;
  logic signed [conv_acc_pkg::ACC_W-1:0] acc, prod, sum, shifted;

  assign param_rd = (state == conv_acc_pkg::LOAD_PARAM) && (param_cnt != 2'd3);
  assign bias_rd  = (state == conv_acc_pkg::LOAD_PARAM) && (param_cnt == 2'd0);
  assign run_rd   = (state == conv_acc_pkg::RUN);

  always_comb begin
    case (param_cnt)
      2'd0:    param_addr = conv_acc_pkg::PARAM_PIXELS;
      2'd1:    param_addr = conv_acc_pkg::PARAM_CHANNELS;
      default: param_addr = conv_acc_pkg::PARAM_SHIFT;
    endcase
  end

  assign prod    = input_rdata_i * weight_rdata_i;
  assign sum     = acc + prod + bias;  // Last product folded in directly
  assign shifted = sum >>> shift;

  // Saturate high while ReLU covers the low side
  always_comb begin
    if (shifted < 0) begin
      result = '0;
    end else if (shifted > 32'sd32767) begin
      result = 16'sh7fff;
    end else begin
      result = shifted[conv_acc_pkg::DATA_W-1:0];
    end
  end

  always_comb begin
    param_req_o       = '0;
    param_req_o.cs    = param_rd;
    param_req_o.oe    = param_rd;
    param_req_o.addr  = param_addr;
    bias_req_o        = '0;
    bias_req_o.cs     = bias_rd;
    bias_req_o.oe     = bias_rd;
    input_req_o       = '0;
    input_req_o.cs    = run_rd;
    input_req_o.oe    = run_rd;
    input_req_o.addr  = in_addr;
    weight_req_o      = '0;
    weight_req_o.cs   = run_rd;
    weight_req_o.oe   = run_rd;
    weight_req_o.addr = ch;
    output_req_o        = '0;
    output_req_o.cs     = out_wr;
    output_req_o.w_req  = out_wr;
    output_req_o.addr   = out_addr;
    output_req_o.w_data = out_data;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state     <= conv_acc_pkg::IDLE;
      param_cnt <= '0;
      mac_vld   <= 1'b0;
      out_wr    <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      mac_vld <= run_rd;
      out_wr  <= 1'b0;
      done_o  <= 1'b0;
      case (state)
        conv_acc_pkg::IDLE: begin
          param_cnt <= '0;
          if (start_i) state <= conv_acc_pkg::LOAD_PARAM;
        end
        conv_acc_pkg::LOAD_PARAM: begin
          param_cnt <= param_cnt + 2'd1;
          if (param_cnt == 2'd3) state <= conv_acc_pkg::RUN;
        end
        conv_acc_pkg::RUN: begin
          if (ch == n_ch - 1'b1) state <= conv_acc_pkg::DRAIN;
        end
        conv_acc_pkg::DRAIN: begin
          out_wr <= 1'b1;
          state  <= (pix == n_pix - 1'b1) ? conv_acc_pkg::DONE : conv_acc_pkg::RUN;
        end
        conv_acc_pkg::DONE: begin
          done_o <= 1'b1;  // One cycle after the last write
          state  <= conv_acc_pkg::IDLE;
        end
        default: state <= conv_acc_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state)
      conv_acc_pkg::LOAD_PARAM: begin
        if (param_cnt == 2'd1) n_pix <= param_rdata_i[conv_acc_pkg::ADDR_W-1:0];
        if (param_cnt == 2'd2) n_ch <= param_rdata_i[conv_acc_pkg::ADDR_W-1:0];
        if (param_cnt == 2'd3) begin
          shift <= param_rdata_i[4:0];
          bias  <= bias_rdata_i;
        end
        pix     <= '0;
        ch      <= '0;
        in_addr <= '0;
        acc     <= '0;
      end
      conv_acc_pkg::RUN: begin
        ch      <= ch + 1'b1;
        in_addr <= in_addr + n_pix;  // Next channel plane
        if (mac_vld) acc <= acc + prod;
      end
      conv_acc_pkg::DRAIN: begin
        out_addr <= pix;
        out_data <= result;
        pix      <= pix + 1'b1;
        ch       <= '0;
        in_addr  <= pix + 1'b1;
        acc      <= '0;
      end
      default: ;
    endcase
  end

endmodule

// File: source/conv_acc_pkg.sv
package conv_acc_pkg;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 10;
  localparam int ACC_W  = 32;

  typedef enum logic [1:0] {
    IDLE_MODE     = 2'd0,
    CONV_1x1_MODE = 2'd1,
    MAX_POOL_MODE = 2'd2
  } conv_acc_mode_t;

  typedef logic signed [DATA_W-1:0] sram_data_t;
  typedef logic        [ADDR_W-1:0] sram_addr_t;

  // One request toward a single-port SRAM
  typedef struct packed {
    logic       cs;
    logic       oe;
    logic       w_req;
    sram_addr_t addr;
    sram_data_t w_data;
  } sram_req_t;

  // Parameter words of the 1x1 conv
  localparam sram_addr_t PARAM_PIXELS   = 10'd0;
  localparam sram_addr_t PARAM_CHANNELS = 10'd1;
  localparam sram_addr_t PARAM_SHIFT    = 10'd2;

  // Parameter words of the max pooling
  localparam sram_addr_t PARAM_WIDTH  = 10'd0;
  localparam sram_addr_t PARAM_HEIGHT = 10'd1;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    LOAD_PARAM = 3'd1,
    RUN        = 3'd2,
    DRAIN      = 3'd3,
    DONE       = 3'd4
  } unit_state_t;

endpackage

// File: source/conv_acc_top.sv
`timescale 1ns/1ps

module conv_acc_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  conv_acc_pkg::conv_acc_mode_t mode_i,
  input  logic                         start_i,
  output logic                         done_o,
  output conv_acc_pkg::sram_req_t      param_req_o,
  input  conv_acc_pkg::sram_data_t     param_rdata_i,
  output conv_acc_pkg::sram_req_t      bias_req_o,
  input  conv_acc_pkg::sram_data_t     bias_rdata_i,
  output conv_acc_pkg::sram_req_t      weight_req_o,
  input  conv_acc_pkg::sram_data_t     weight_rdata_i,
  output conv_acc_pkg::sram_req_t      input_req_o,
  input  conv_acc_pkg::sram_data_t     input_rdata_i,
  output conv_acc_pkg::sram_req_t      output_req_o,
  input  conv_acc_pkg::sram_data_t     output_rdata_i
);

  logic                     conv_clk, pool_clk;
  logic                     conv_start, conv_done, pool_start, pool_done;
  conv_acc_pkg::sram_req_t  conv_param_req, conv_bias_req, conv_weight_req;
  conv_acc_pkg::sram_req_t  conv_input_req, conv_output_req;
  conv_acc_pkg::sram_data_t conv_param_rdata, conv_bias_rdata, conv_weight_rdata;
  conv_acc_pkg::sram_data_t conv_input_rdata, conv_output_rdata;
  conv_acc_pkg::sram_req_t  pool_param_req, pool_input_req, pool_output_req;
  conv_acc_pkg::sram_data_t pool_param_rdata, pool_input_rdata, pool_output_rdata;

  bus_switcher i_bus_switcher (
    .clk_i, .reset_i, .mode_i, .start_i, .done_o,
    .param_req_o, .param_rdata_i, .bias_req_o, .bias_rdata_i,
    .weight_req_o, .weight_rdata_i, .input_req_o, .input_rdata_i,
    .output_req_o, .output_rdata_i,
    .conv_clk_o          (conv_clk),
    .conv_start_o        (conv_start),
    .conv_done_i         (conv_done),
    .conv_param_req_i    (conv_param_req),
    .conv_param_rdata_o  (conv_param_rdata),
    .conv_bias_req_i     (conv_bias_req),
    .conv_bias_rdata_o   (conv_bias_rdata),
    .conv_weight_req_i   (conv_weight_req),
    .conv_weight_rdata_o (conv_weight_rdata),
    .conv_input_req_i    (conv_input_req),
    .conv_input_rdata_o  (conv_input_rdata),
    .conv_output_req_i   (conv_output_req),
    .conv_output_rdata_o (conv_output_rdata),
    .pool_clk_o          (pool_clk),
    .pool_start_o        (pool_start),
    .pool_done_i         (pool_done),
    .pool_param_req_i    (pool_param_req),
    .pool_param_rdata_o  (pool_param_rdata),
    .pool_input_req_i    (pool_input_req),
    .pool_input_rdata_o  (pool_input_rdata),
    .pool_output_req_i   (pool_output_req),
    .pool_output_rdata_o (pool_output_rdata)
  );

  conv_1x1_unit i_conv_1x1 (
    .clk_i          (conv_clk),
    .reset_i        (reset_i),
    .start_i        (conv_start),
    .done_o         (conv_done),
    .param_req_o    (conv_param_req),
    .param_rdata_i  (conv_param_rdata),
    .bias_req_o     (conv_bias_req),
    .bias_rdata_i   (conv_bias_rdata),
    .weight_req_o   (conv_weight_req),
    .weight_rdata_i (conv_weight_rdata),
    .input_req_o    (conv_input_req),
    .input_rdata_i  (conv_input_rdata),
    .output_req_o   (conv_output_req),
    .output_rdata_i (conv_output_rdata)
  );

  maxpool_unit i_maxpool (
    .clk_i          (pool_clk),
    .reset_i        (reset_i),
    .start_i        (pool_start),
    .done_o         (pool_done),
    .param_req_o    (pool_param_req),
    .param_rdata_i  (pool_param_rdata),
    .input_req_o    (pool_input_req),
    .input_rdata_i  (pool_input_rdata),
    .output_req_o   (pool_output_req),
    .output_rdata_i (pool_output_rdata)
  );

endmodule

// File: source/maxpool_unit.sv
`timescale 1ns/1ps

module maxpool_unit (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     start_i,
  output logic                     done_o,
  output conv_acc_pkg::sram_req_t  param_req_o,
  input  conv_acc_pkg::sram_data_t param_rdata_i,
  output conv_acc_pkg::sram_req_t  input_req_o,
  input  conv_acc_pkg::sram_data_t input_rdata_i,
  output conv_acc_pkg::sram_req_t  output_req_o,
  input  conv_acc_pkg::sram_data_t output_rdata_i
);

  conv_acc_pkg::unit_state_t state;
  logic [1:0]                param_cnt, win;
  conv_acc_pkg::sram_addr_t  width, height, x, y, row_base, out_idx, out_addr, rd_addr;
  conv_acc_pkg::sram_data_t  max_val, win_max, out_data;
  logic                      param_rd, run_rd, rd_vld, rd_first, out_wr, last_x, last_y;

  assign param_rd = (state == conv_acc_pkg::LOAD_PARAM) && (param_cnt != 2'd2);
  assign run_rd   = (state == conv_acc_pkg::RUN);
  assign last_x   = (x == (width >> 1) - 1'b1);
  assign last_y   = (y == (height >> 1) - 1'b1);

  // Windows read top left then top right then bottom left then bottom right
  assign rd_addr = row_base + {x[conv_acc_pkg::ADDR_W-2:0], 1'b0} +
                   (win[1] ? width : '0) + win[0];
  assign win_max = (input_rdata_i > max_val) ? input_rdata_i : max_val;

  always_comb begin
    param_req_o         = '0;
    param_req_o.cs      = param_rd;
    param_req_o.oe      = param_rd;
    param_req_o.addr    = param_cnt[0] ? conv_acc_pkg::PARAM_HEIGHT : conv_acc_pkg::PARAM_WIDTH;
    input_req_o         = '0;
    input_req_o.cs      = run_rd;
    input_req_o.oe      = run_rd;
    input_req_o.addr    = rd_addr;
    output_req_o        = '0;
    output_req_o.cs     = out_wr;
    output_req_o.w_req  = out_wr;
    output_req_o.addr   = out_addr;
    output_req_o.w_data = out_data;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state     <= conv_acc_pkg::IDLE;
      param_cnt <= '0;
      rd_vld    <= 1'b0;
      out_wr    <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      rd_vld <= run_rd;
      out_wr <= 1'b0;
      done_o <= 1'b0;
      case (state)
        conv_acc_pkg::IDLE: begin
          param_cnt <= '0;
          if (start_i) state <= conv_acc_pkg::LOAD_PARAM;
        end
        conv_acc_pkg::LOAD_PARAM: begin
          param_cnt <= param_cnt + 2'd1;
          if (param_cnt == 2'd2) state <= conv_acc_pkg::RUN;
        end
        conv_acc_pkg::RUN: if (win == 2'd3) state <= conv_acc_pkg::DRAIN;
        conv_acc_pkg::DRAIN: begin
          out_wr <= 1'b1;
          state  <= (last_x && last_y) ? conv_acc_pkg::DONE : conv_acc_pkg::RUN;
        end
        conv_acc_pkg::DONE: begin
          done_o <= 1'b1;
          state  <= conv_acc_pkg::IDLE;
        end
        default: state <= conv_acc_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    rd_first <= run_rd && (win == 2'd0);
    case (state)
      conv_acc_pkg::LOAD_PARAM: begin
        if (param_cnt == 2'd1) width <= param_rdata_i[conv_acc_pkg::ADDR_W-1:0];
        if (param_cnt == 2'd2) height <= param_rdata_i[conv_acc_pkg::ADDR_W-1:0];
        x        <= '0;
        y        <= '0;
        win      <= '0;
        row_base <= '0;
        out_idx  <= '0;
      end
      conv_acc_pkg::RUN: begin
        win <= win + 2'd1;  // Wraps to 0 for the next window
        if (rd_vld) max_val <= rd_first ? input_rdata_i : win_max;
      end
      conv_acc_pkg::DRAIN: begin
        out_addr <= out_idx;
        out_data <= win_max;  // Fourth value arrives here
        out_idx  <= out_idx + 1'b1;
        if (last_x) begin
          x        <= '0;
          y        <= y + 1'b1;
          row_base <= row_base + width + width;
        end else begin
          x <= x + 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule
